//--- hdl/icache_geom_pkg.sv
package icache_geom_pkg;

    // cache shape
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;

    // address field widths from low to high
    localparam int BYTE_OFS_W = 2;
    localparam int WORD_SEL_W = 2;
    localparam int SET_W      = 3;
    localparam int WAY_W      = 2;
    localparam int TAG_W      = 25;

    // field positions inside a byte address
    localparam int WORD_LSB = BYTE_OFS_W;
    localparam int SET_LSB  = BYTE_OFS_W + WORD_SEL_W;  // also the block offset width
    localparam int TAG_LSB  = SET_LSB + SET_W;

    // flat store indices
    localparam int TAG_IDX_W  = SET_W + WAY_W;               // {set, way}
    localparam int DATA_IDX_W = SET_W + WAY_W + WORD_SEL_W;  // {set, way, word}

    typedef logic [SET_W-1:0]      set_idx_t;
    typedef logic [WAY_W-1:0]      way_idx_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [TAG_W-1:0]      tag_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

//--- hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    // shared by the fetch port and the sdram port
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;  // byte address
    typedef logic [DATA_W-1:0] data_t;  // instruction or memory word

endpackage

//--- hdl/way_store.sv
`timescale 1ns/10ps

module way_store #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2,
    parameter int  RD_PORTS  = 1,
    localparam int AW        = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic            Clk,
    input  logic            arst_n,
    input  logic            wr_en,
    input  logic [AW-1:0]   wr_addr,
    input  payload_t        wr_data,
    input  logic [AW-1:0]   rd_addr [RD_PORTS],
    output payload_t        rd_data [RD_PORTS]
);

    payload_t mem [DEPTH];

    // zero on reset so tag entries come up invalid
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one combinational read per port
    for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
        assign rd_data[p] = mem[rd_addr[p]];
    end

endmodule

//--- hdl/tag_lookup.sv
`timescale 1ns/10ps

module tag_lookup (
    input  logic                      Clk,
    input  logic                      arst_n,
    input  icache_geom_pkg::set_idx_t set_idx,
    input  icache_geom_pkg::tag_t     tag,
    input  logic                      fill_done,
    input  icache_geom_pkg::way_idx_t fill_way,
    output logic                      hit,
    output icache_geom_pkg::way_idx_t hit_way,
    output icache_geom_pkg::way_idx_t victim_way
);

    icache_geom_pkg::tag_entry_t entry      [icache_geom_pkg::NUM_WAYS];
    logic [icache_geom_pkg::TAG_IDX_W-1:0] entry_addr [icache_geom_pkg::NUM_WAYS];
    icache_geom_pkg::tag_entry_t new_entry;
    icache_geom_pkg::way_idx_t   rr_ptr     [icache_geom_pkg::NUM_SETS];
    logic                        all_valid;

    // every way of the set is read at once
    for (genvar w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin : g_addr
        assign entry_addr[w] = {set_idx, icache_geom_pkg::way_idx_t'(w)};
    end

    assign new_entry.valid = 1'b1;
    assign new_entry.tag   = tag;

    way_store #(
        .payload_t (icache_geom_pkg::tag_entry_t),
        .DEPTH     (icache_geom_pkg::NUM_SETS * icache_geom_pkg::NUM_WAYS),
        .RD_PORTS  (icache_geom_pkg::NUM_WAYS)
    ) u_tags (
        .Clk     (Clk),
        .arst_n  (arst_n),
        .wr_en   (fill_done),
        .wr_addr ({set_idx, fill_way}),
        .wr_data (new_entry),
        .rd_addr (entry_addr),
        .rd_data (entry)
    );

    // walk from the top way down so the lowest way wins
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        all_valid  = 1'b1;
        victim_way = rr_ptr[set_idx];  // used only when the set is full
        for (int w = icache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!entry[w].valid) begin
                all_valid  = 1'b0;
                victim_way = icache_geom_pkg::way_idx_t'(w);
            end
            if (entry[w].valid && (entry[w].tag == tag)) begin
                hit     = 1'b1;
                hit_way = icache_geom_pkg::way_idx_t'(w);
            end
        end
    end

    // round robin only moves when it picked the victim
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < icache_geom_pkg::NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill_done && all_valid) begin
            rr_ptr[set_idx] <= rr_ptr[set_idx] + 1'b1;
        end
    end

endmodule

//--- hdl/refill_counter.sv
`timescale 1ns/10ps

module refill_counter (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic                       word_strobe,
    output icache_geom_pkg::word_sel_t word_idx,
    output logic                       last_word
);

    icache_geom_pkg::word_sel_t cnt;

    // start wins over a strobe in the same cycle
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= '0;
        end else if (word_strobe) begin
            cnt <= cnt + 1'b1;  // wraps back to 0 after the last word
        end
    end

    assign word_idx = cnt;

    // high only in the cycle the final word is on the bus
    assign last_word = word_strobe &&
                       (cnt == icache_geom_pkg::word_sel_t'(icache_geom_pkg::BLOCK_WORDS - 1));

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                                   Clk,
    input  logic                                   arst_n,
    input  logic                                   read_enable,
    input  mem_bus_pkg::addr_t                     read_address,
    input  logic                                   hit,
    input  icache_geom_pkg::way_idx_t              hit_way,
    input  icache_geom_pkg::way_idx_t              victim_way,
    input  logic                                   last_word,
    input  icache_geom_pkg::word_sel_t             word_idx,
    input  mem_bus_pkg::data_t                     rd_data,
    input  mem_bus_pkg::data_t                     mem_data_in,
    input  logic                                   mem_data_ready,
    output icache_geom_pkg::set_idx_t              lookup_set,
    output icache_geom_pkg::tag_t                  lookup_tag,
    output logic [icache_geom_pkg::DATA_IDX_W-1:0] rd_addr,
    output icache_geom_pkg::way_idx_t              fill_way,
    output logic                                   fill_done,
    output logic                                   counter_start,
    output logic                                   data_wr_en,
    output logic                                   ready,
    output logic                                   busy,
    output mem_bus_pkg::data_t                     instruction,
    output mem_bus_pkg::addr_t                     mem_read_address,
    output logic                                   mem_read_request
);

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        RESPOND
    } state_t;

    state_t                     state, state_nxt;
    mem_bus_pkg::addr_t         req_addr;   // latched miss address
    icache_geom_pkg::way_idx_t  req_way;    // way being refilled
    mem_bus_pkg::data_t         instr_q;
    logic                       ready_q;
    logic                       in_refill;
    logic                       accept;
    icache_geom_pkg::set_idx_t  fetch_set, req_set;
    icache_geom_pkg::tag_t      fetch_tag, req_tag;
    icache_geom_pkg::word_sel_t fetch_word, req_word;

    // address fields both live and latched
    assign fetch_set  = read_address[icache_geom_pkg::SET_LSB +: icache_geom_pkg::SET_W];
    assign fetch_tag  = read_address[icache_geom_pkg::TAG_LSB +: icache_geom_pkg::TAG_W];
    assign fetch_word = read_address[icache_geom_pkg::WORD_LSB +: icache_geom_pkg::WORD_SEL_W];
    assign req_set    = req_addr[icache_geom_pkg::SET_LSB +: icache_geom_pkg::SET_W];
    assign req_tag    = req_addr[icache_geom_pkg::TAG_LSB +: icache_geom_pkg::TAG_W];
    assign req_word   = req_addr[icache_geom_pkg::WORD_LSB +: icache_geom_pkg::WORD_SEL_W];

    assign in_refill = (state == REFILL);
    assign accept    = read_enable && !in_refill;  // strobes during busy are dropped

    // lookup follows the core except while a refill owns the set
    assign lookup_set    = in_refill ? req_set : fetch_set;
    assign lookup_tag    = in_refill ? req_tag : fetch_tag;
    assign rd_addr       = {fetch_set, hit_way, fetch_word};
    assign fill_way      = req_way;
    assign fill_done     = in_refill && last_word;
    assign counter_start = accept && !hit;
    assign data_wr_en    = in_refill && mem_data_ready;

    assign busy             = in_refill;
    assign mem_read_request = in_refill;
    assign mem_read_address = {req_addr[mem_bus_pkg::ADDR_W-1:icache_geom_pkg::SET_LSB],
                               {icache_geom_pkg::SET_LSB{1'b0}}};  // block aligned
    assign ready            = ready_q;
    assign instruction      = instr_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, RESPOND: begin
                // respond cycle already sees the new block
                if (accept && !hit) begin
                    state_nxt = REFILL;
                end else begin
                    state_nxt = IDLE;
                end
            end
            REFILL: begin
                if (last_word) begin
                    state_nxt = RESPOND;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            ready_q  <= 1'b0;
            req_addr <= '0;
            req_way  <= '0;
        end else begin
            state   <= state_nxt;
            ready_q <= (accept && hit) || fill_done;  // single cycle pulse
            if (counter_start) begin
                req_addr <= read_address;
                req_way  <= victim_way;
            end
        end
    end

    // hit word or the requested word as it streams in
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_q <= '0;
        end else if (accept && hit) begin
            instr_q <= rd_data;
        end else if (data_wr_en && (word_idx == req_word)) begin
            instr_q <= mem_data_in;
        end
    end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic               Clk,
    input  logic               arst_n,
    input  logic               read_enable,
    input  mem_bus_pkg::addr_t read_address,
    output mem_bus_pkg::data_t instruction,
    output logic               ready,
    output logic               busy,
    output mem_bus_pkg::addr_t mem_read_address,
    output logic               mem_read_request,
    input  mem_bus_pkg::data_t mem_data_in,
    input  logic               mem_data_ready
);

    icache_geom_pkg::set_idx_t              lookup_set;
    icache_geom_pkg::tag_t                  lookup_tag;
    logic                                   hit;
    icache_geom_pkg::way_idx_t              hit_way;
    icache_geom_pkg::way_idx_t              victim_way;
    icache_geom_pkg::way_idx_t              fill_way;
    logic                                   fill_done;
    logic                                   counter_start;
    icache_geom_pkg::word_sel_t             word_idx;
    logic                                   last_word;
    logic                                   data_wr_en;
    logic [icache_geom_pkg::DATA_IDX_W-1:0] data_rd_addr [1];
    mem_bus_pkg::data_t                     data_rd      [1];

    icache_ctrl u_ctrl (
        .Clk              (Clk),
        .arst_n           (arst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .last_word        (last_word),
        .word_idx         (word_idx),
        .rd_data          (data_rd[0]),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .lookup_set       (lookup_set),
        .lookup_tag       (lookup_tag),
        .rd_addr          (data_rd_addr[0]),
        .fill_way         (fill_way),
        .fill_done        (fill_done),
        .counter_start    (counter_start),
        .data_wr_en       (data_wr_en),
        .ready            (ready),
        .busy             (busy),
        .instruction      (instruction),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request)
    );

    refill_counter u_cnt (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .start       (counter_start),
        .word_strobe (mem_data_ready),
        .word_idx    (word_idx),
        .last_word   (last_word)
    );

    tag_lookup u_tags (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .set_idx    (lookup_set),
        .tag        (lookup_tag),
        .fill_done  (fill_done),
        .fill_way   (fill_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    // one word per entry indexed {set, way, word}
    way_store #(
        .payload_t (mem_bus_pkg::data_t),
        .DEPTH     (icache_geom_pkg::NUM_SETS * icache_geom_pkg::NUM_WAYS *
                    icache_geom_pkg::BLOCK_WORDS),
        .RD_PORTS  (1)
    ) u_data (
        .Clk     (Clk),
        .arst_n  (arst_n),
        .wr_en   (data_wr_en),
        .wr_addr ({lookup_set, fill_way, word_idx}),
        .wr_data (mem_data_in),
        .rd_addr (data_rd_addr),
        .rd_data (data_rd)
    );

endmodule

//--- dv/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam logic [31:0] SEED       = 32'hd767_13c0;
    localparam int          WAIT_LIMIT = 100;  // cycles per wait

    logic               Clk = 1'b0;
    logic               arst_n;
    logic               read_enable;
    mem_bus_pkg::addr_t read_address;
    mem_bus_pkg::data_t instruction;
    logic               ready;
    logic               busy;
    mem_bus_pkg::addr_t mem_read_address;
    logic               mem_read_request;
    mem_bus_pkg::data_t mem_data_in    = '0;
    logic               mem_data_ready = 1'b0;

    logic               last_strobe = 1'b0;  // high with the final word of a block
    logic               started;             // first fetch has been driven
    logic               exp_hit;
    mem_bus_pkg::data_t exp_word;
    mem_bus_pkg::addr_t exp_block;
    logic [31:0]        gap_state  = SEED;
    logic [31:0]        addr_state = SEED;
    int err_quiet, err_resp, err_req, err_stable, err_ready, err_rise, timeouts, hits, misses;

    // reference cache state
    icache_geom_pkg::tag_t     ref_tag   [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS];
    logic                      ref_valid [icache_geom_pkg::NUM_SETS][icache_geom_pkg::NUM_WAYS];
    icache_geom_pkg::way_idx_t ref_ptr   [icache_geom_pkg::NUM_SETS];

    icache_top UUT (
        .Clk              (Clk),
        .arst_n           (arst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    always #10 Clk = ~Clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic mem_bus_pkg::data_t model_word(input mem_bus_pkg::addr_t a);
        return a * 32'h9e37_79b1;  // sdram content pattern
    endfunction

    function automatic logic ref_hit(input mem_bus_pkg::addr_t a);
        icache_geom_pkg::set_idx_t s;
        s = a[icache_geom_pkg::SET_LSB +: icache_geom_pkg::SET_W];
        for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
            if (ref_valid[s][w] &&
                ref_tag[s][w] == a[icache_geom_pkg::TAG_LSB +: icache_geom_pkg::TAG_W]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic ref_fill(input mem_bus_pkg::addr_t a);
        icache_geom_pkg::set_idx_t s;
        icache_geom_pkg::way_idx_t v;
        logic                      found;
        s     = a[icache_geom_pkg::SET_LSB +: icache_geom_pkg::SET_W];
        v     = ref_ptr[s];
        found = 1'b0;
        for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
            if (!found && !ref_valid[s][w]) begin
                found = 1'b1;
                v     = icache_geom_pkg::way_idx_t'(w);  // lowest free way
            end
        end
        if (!found) ref_ptr[s] = ref_ptr[s] + 1'b1;  // set full so round robin picks the victim
        ref_valid[s][v] = 1'b1;
        ref_tag[s][v]   = a[icache_geom_pkg::TAG_LSB +: icache_geom_pkg::TAG_W];
    endtask

    // one fetch strobe with the prediction taken before the reference updates
    task automatic issue(input mem_bus_pkg::addr_t a);
        if (timeouts != 0) return;
        exp_hit   = ref_hit(a);
        exp_word  = model_word(a);
        exp_block = a & 32'hffff_fff0;
        if (exp_hit) hits++;
        else begin
            misses++;
            ref_fill(a);
        end
        read_address = a;
        read_enable  = 1'b1;
        started      = 1'b1;
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
    endtask

    task automatic wait_ready;
        int waited;
        waited = 0;
        if (timeouts != 0) return;
        while (!ready && waited < WAIT_LIMIT) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (!ready) begin
            timeouts++;
            $display("timeout: the cache never answered the fetch");
        end
        @(posedge Clk);  // keeps exp_word steady past the sample point
        #1;
    endtask

    task automatic wait_busy;
        int waited;
        waited = 0;
        while (!busy && waited < WAIT_LIMIT && timeouts == 0) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (!busy && timeouts == 0) begin
            timeouts++;
            $display("timeout: the cache never went busy on a miss");
        end
    endtask

    task automatic fetch(input mem_bus_pkg::addr_t a);
        issue(a);
        wait_ready();
    endtask

    // sdram answers each request with one block and random gaps before each word
    always begin : sdram_model
        mem_bus_pkg::addr_t base;
        int                 gap;
        @(posedge Clk);
        #1;
        if (arst_n && mem_read_request) begin
            base = mem_read_address;
            for (int i = 0; i < icache_geom_pkg::BLOCK_WORDS; i++) begin
                gap_state = lcg_step(gap_state);
                gap       = int'(gap_state[17:16]);
                for (int g = 0; g < gap; g++) begin
                    @(posedge Clk);
                    #1;
                end
                mem_data_ready = 1'b1;
                mem_data_in    = model_word(base + mem_bus_pkg::addr_t'(4 * i));
                last_strobe    = (i == icache_geom_pkg::BLOCK_WORDS - 1);
                @(posedge Clk);
                #1;
                mem_data_ready = 1'b0;
                last_strobe    = 1'b0;
            end
        end
    end

    // checks sample at the falling edge away from both drivers
    quiet_after_reset: assert property (@(negedge Clk) disable iff (!arst_n)
        !started |-> (!ready && !busy && !mem_read_request))
        else begin
            err_quiet++;
            $display("error: idle ready=%h busy=%h mem_read_request=%h",
                     ready, busy, mem_read_request);
        end

    response_word: assert property (@(negedge Clk) disable iff (!arst_n)
        ($past(read_enable && !busy && exp_hit) || $past(last_strobe)) |->
            (ready && !busy && !mem_read_request && instruction == exp_word))
        else begin
            err_resp++;
            $display("error: ready=%h busy=%h mem_read_request=%h instruction=%h expected %h",
                     ready, busy, mem_read_request, instruction, exp_word);
        end

    miss_request: assert property (@(negedge Clk) disable iff (!arst_n)
        $past(read_enable && !busy && !exp_hit) |->
            (busy && mem_read_request && mem_read_address == exp_block))
        else begin
            err_req++;
            $display("error: busy=%h mem_read_request=%h mem_read_address=%h expected %h",
                     busy, mem_read_request, mem_read_address, exp_block);
        end

    address_stable: assert property (@(negedge Clk) disable iff (!arst_n)
        (mem_read_request && $past(mem_read_request)) |-> $stable(mem_read_address))
        else begin
            err_stable++;
            $display("error: mem_read_address=%h moved during a request", mem_read_address);
        end

    no_extra_ready: assert property (@(negedge Clk) disable iff (!arst_n)
        ready |-> ($past(read_enable && !busy && exp_hit) || $past(last_strobe)))
        else begin
            err_ready++;
            $display("error: ready=%h without a hit or a finished refill", ready);
        end

    no_extra_request: assert property (@(negedge Clk) disable iff (!arst_n)
        (mem_read_request && !$past(mem_read_request)) |->
            $past(read_enable && !busy && !exp_hit))
        else begin
            err_rise++;
            $display("error: mem_read_request=%h rose without a predicted miss",
                     mem_read_request);
        end

    initial begin
        int total;
        arst_n       = 1'b0;
        read_enable  = 1'b0;
        read_address = '0;
        started      = 1'b0;
        exp_hit      = 1'b0;
        exp_word     = '0;
        exp_block    = '0;
        for (int s = 0; s < icache_geom_pkg::NUM_SETS; s++) begin
            ref_ptr[s] = '0;
            for (int w = 0; w < icache_geom_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (2) @(posedge Clk);
        #1;
        arst_n = 1'b1;
        repeat (3) begin
            @(posedge Clk);
            #1;
        end
        fetch(32'h0000_1008);  // cold miss
        for (int w = 0; w < icache_geom_pkg::BLOCK_WORDS; w++)
            fetch(32'h0000_1000 + mem_bus_pkg::addr_t'(4 * w));
        // five blocks in set 2 where the fifth pushes out way 0
        for (int k = 0; k < 5; k++)
            fetch(32'h0000_2024 + mem_bus_pkg::addr_t'(k * 128));
        for (int k = 1; k < 4; k++)
            fetch(32'h0000_2024 + mem_bus_pkg::addr_t'(k * 128));
        fetch(32'h0000_2024);
        // strobe of a cached word in the middle of a refill
        issue(32'h0000_3044);
        wait_busy();
        read_address = 32'h0000_1004;
        read_enable  = 1'b1;
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
        wait_ready();
        for (int n = 0; n < 200; n++) begin
            addr_state = lcg_step(addr_state);
            fetch(32'h0001_0000 | (addr_state & 32'h0000_03fc));  // 64 blocks over 8 sets
        end
        total = err_quiet + err_resp + err_req + err_stable + err_ready + err_rise + timeouts;
        $write("errors: quiet %0d response %0d request %0d stable %0d ready %0d",
               err_quiet, err_resp, err_req, err_stable, err_ready);
        $display(" rise %0d timeout %0d (hits %0d misses %0d)",
                 err_rise, timeouts, hits, misses);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/icache_geom_pkg.sv
hdl/mem_bus_pkg.sv
hdl/way_store.sv
hdl/tag_lookup.sv
hdl/refill_counter.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module icache_tb -f src.f -o icache_sim
out=$(./obj_dir/icache_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
